//--- src/sampler_settings.svh
`ifndef SAMPLER_SETTINGS_SVH
`define SAMPLER_SETTINGS_SVH

// apb address width and input synchronizer depth.
`define SAMPLER_ADDR_BITS 5
`define SAMPLER_SYNC_STAGES 2

// reset defaults of the run-time registers.
`define SAMPLER_DEFAULT_BAUD_DIV 16'd16
`define SAMPLER_DEFAULT_DECIM 8'd64

// register offsets.
`define SAMPLER_REG_CTRL 5'h00
`define SAMPLER_REG_BAUD 5'h04
`define SAMPLER_REG_DECIM 5'h08
`define SAMPLER_REG_DUTY 5'h0C
`define SAMPLER_REG_STATUS 5'h10

`endif

//--- src/serial_pkg.sv
`default_nettype none

package serial_pkg;

    // one uart character.
    typedef logic [7:0] byte_t;

    // clocks per bit.
    typedef logic [15:0] baud_div_t;

    // shared by the receiver and the transmit serializer.
    typedef enum logic [1:0] {
        uart_idle,
        uart_start,
        uart_data,
        uart_stop
    } uart_state_t;

endpackage

`default_nettype wire

//--- src/capture_pkg.sv
`default_nettype none

package capture_pkg;

    // ones count over one decimation window.
    typedef logic [7:0] sample_t;

    // window length in clocks.
    typedef logic [7:0] decim_t;

    // pwm compare value.
    typedef logic [7:0] duty_t;

    // saturating framing error count.
    typedef logic [7:0] err_count_t;

    typedef enum logic {
        cap_idle,
        cap_run
    } capture_state_t;

endpackage

`default_nettype wire

//--- src/acia_rx.sv
`timescale 1ns/1ns
`default_nettype none

module acia_rx (
    input  wire                   clk,
    input  wire                   reset,
    input  wire serial_pkg::baud_div_t baud_div,
    input  wire                   rx_serial,
    output serial_pkg::byte_t     rx_dat,
    output logic                  rx_stb,
    output logic                  rx_err
);

    import serial_pkg::*;

    logic [1:0]  rx_sync;
    logic        rx_prev;
    logic        rx_s;
    logic        bit_end;
    uart_state_t state;
    baud_div_t   baud_cnt;
    logic [2:0]  bit_idx;
    byte_t       shift;

    assign rx_s    = rx_sync[1];
    assign bit_end = baud_cnt == baud_div - 16'd1;

    // line idles high.
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_sync <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rx_serial};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk) begin
        rx_stb <= 1'b0;
        rx_err <= 1'b0;
        if (reset) begin
            state    <= uart_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            case (state)
                uart_idle: begin
                    // only a falling edge starts a frame so a low stop bit cannot restart.
                    if (rx_prev && !rx_s) begin
                        baud_cnt <= '0;
                        state    <= uart_start;
                    end
                end
                uart_start: begin
                    if (baud_cnt == (baud_div >> 1) - 16'd1) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_s ? uart_idle : uart_data;
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
                uart_data: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        shift    <= {rx_s, shift[7:1]};
                        bit_idx  <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= uart_stop;
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        state    <= uart_idle;
                        if (rx_s) begin
                            rx_stb <= 1'b1;
                            rx_dat <= shift;
                        end else begin
                            rx_err <= 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
            endcase
        end
    end

    stb_err_excl: assert property (@(posedge clk) disable iff (reset) !(rx_stb && rx_err));

endmodule

`default_nettype wire

//--- src/digitizer.sv
`timescale 1ns/1ns
`default_nettype none

`include "sampler_settings.svh"

module digitizer (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   lvds_in,
    input  wire capture_pkg::decim_t decim,
    output logic                  comp_in,
    output capture_pkg::sample_t  sample,
    output logic                  sample_valid,
    input  wire                   sample_ready
);

    import capture_pkg::*;

    logic [`SAMPLER_SYNC_STAGES-1:0] sync;
    logic    sig;
    decim_t  win_cnt;
    sample_t ones;

    assign sig = sync[`SAMPLER_SYNC_STAGES-1];

    always_ff @(posedge clk) begin
        sync <= {sync[`SAMPLER_SYNC_STAGES-2:0], lvds_in};
    end

    // comparator feedback.
    always_ff @(posedge clk) begin
        if (reset)
            comp_in <= 1'b0;
        else
            comp_in <= sig;
    end

    ////////////////////
    // decimator.
    always_ff @(posedge clk) begin
        if (reset) begin
            win_cnt      <= '0;
            ones         <= '0;
            sample_valid <= 1'b0;
        end else if (sample_valid) begin
            // counting holds until the result is taken.
            if (sample_ready)
                sample_valid <= 1'b0;
        end else if (win_cnt >= decim - 8'd1) begin
            sample       <= ones + sample_t'(sig);
            sample_valid <= 1'b1;
            win_cnt      <= '0;
            ones         <= '0;
        end else begin
            win_cnt <= win_cnt + 8'd1;
            ones    <= ones + sample_t'(sig);
        end
    end

    sample_in_range: assert property (@(posedge clk) disable iff (reset)
        sample_valid |-> sample <= decim);

endmodule

`default_nettype wire

//--- src/capture_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module capture_ctrl (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   enable,
    input  wire serial_pkg::byte_t rx_dat,
    input  wire                   rx_stb,
    input  wire capture_pkg::sample_t sample,
    input  wire                   sample_valid,
    output logic                  sample_ready,
    output capture_pkg::sample_t  dump_sample,
    output logic                  dump_valid,
    output logic                  dump_last,
    input  wire                   dump_ready,
    output logic                  busy
);

    import serial_pkg::*;
    import capture_pkg::*;

    capture_state_t state;
    byte_t          remaining;

    assign busy         = state == cap_run;
    // idle drains the digitizer.
    assign sample_ready = busy ? dump_ready : 1'b1;
    assign dump_valid   = busy && sample_valid;
    assign dump_sample  = sample;
    assign dump_last    = remaining == 8'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= cap_idle;
            remaining <= '0;
        end else if (state == cap_idle) begin
            if (rx_stb && enable && rx_dat != 8'd0) begin
                remaining <= rx_dat;
                state     <= cap_run;
            end
        end else if (dump_valid && dump_ready) begin
            remaining <= remaining - 8'd1;
            if (dump_last)
                state <= cap_idle;
        end
    end

    no_dump_idle: assert property (@(posedge clk) disable iff (reset)
        state == cap_idle |-> !dump_valid);

endmodule

`default_nettype wire

//--- src/hex_dump.sv
`timescale 1ns/1ns
`default_nettype none

module hex_dump (
    input  wire                   clk,
    input  wire                   reset,
    input  wire serial_pkg::baud_div_t baud_div,
    input  wire capture_pkg::sample_t dump_sample,
    input  wire                   dump_valid,
    input  wire                   dump_last,
    output logic                  dump_ready,
    output logic                  tx_serial
);

    import serial_pkg::*;
    import capture_pkg::*;

    uart_state_t state;
    baud_div_t   baud_cnt;
    logic        bit_end;
    logic [2:0]  bit_idx;
    logic [2:0]  char_idx;
    logic [2:0]  last_char;
    byte_t       shift;
    sample_t     held;
    logic        held_last;

    function automatic byte_t hex_char(input logic [3:0] nib);
        return (nib < 4'd10) ? 8'h30 + byte_t'(nib) : 8'h37 + byte_t'(nib);
    endfunction

    // "HH " and, after the last sample, CR LF.
    function automatic byte_t seq_char(input logic [2:0] idx, input sample_t smp);
        case (idx)
            3'd0: return hex_char(smp[7:4]);
            3'd1: return hex_char(smp[3:0]);
            3'd2: return 8'h20;
            3'd3: return 8'h0D;
            default: return 8'h0A;
        endcase
    endfunction

    assign bit_end    = baud_cnt == baud_div - 16'd1;
    assign last_char  = held_last ? 3'd4 : 3'd2;
    assign dump_ready = state == uart_idle;

    assign tx_serial = (state == uart_start) ? 1'b0 :
                       (state == uart_data)  ? shift[0] : 1'b1;

    ////////////////////
    // character serializer.
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= uart_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            char_idx <= '0;
        end else begin
            case (state)
                uart_idle: begin
                    if (dump_valid) begin
                        held      <= dump_sample;
                        held_last <= dump_last;
                        shift     <= seq_char(3'd0, dump_sample);
                        char_idx  <= '0;
                        baud_cnt  <= '0;
                        state     <= uart_start;
                    end
                end
                uart_start: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= uart_data;
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
                uart_data: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        shift    <= shift >> 1;
                        bit_idx  <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= uart_stop;
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        if (char_idx == last_char) begin
                            state <= uart_idle;
                        end else begin
                            char_idx <= char_idx + 3'd1;
                            shift    <= seq_char(char_idx + 3'd1, held);
                            state    <= uart_start;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "sampler_settings.svh"

module apb_regs (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire [`SAMPLER_ADDR_BITS-1:0] paddr,
    input  wire [31:0]                   pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  wire                          rx_err,
    input  wire                          busy,
    output logic                         enable,
    output serial_pkg::baud_div_t        baud_div,
    output capture_pkg::decim_t          decim,
    output logic                         pwm_out,
    output logic                         led_err
);

    import serial_pkg::*;
    import capture_pkg::*;

    logic       access;
    logic       wr_en;
    logic       mapped;
    duty_t      duty;
    duty_t      pwm_cnt;
    err_count_t err_count;

    assign access  = psel && penable;
    assign wr_en   = access && pwrite && mapped;
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;
    assign led_err = err_count != 8'd0;

    always_comb begin
        prdata = '0;
        mapped = 1'b1;
        case (paddr)
            `SAMPLER_REG_CTRL:   prdata = {31'd0, enable};
            `SAMPLER_REG_BAUD:   prdata = {16'd0, baud_div};
            `SAMPLER_REG_DECIM:  prdata = {24'd0, decim};
            `SAMPLER_REG_DUTY:   prdata = {24'd0, duty};
            `SAMPLER_REG_STATUS: prdata = {16'd0, err_count, 7'd0, busy};
            default:             mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            enable    <= 1'b0;
            baud_div  <= `SAMPLER_DEFAULT_BAUD_DIV;
            decim     <= `SAMPLER_DEFAULT_DECIM;
            duty      <= '0;
            err_count <= '0;
        end else begin
            if (rx_err && err_count != 8'hFF)
                err_count <= err_count + 8'd1;
            if (wr_en) begin
                case (paddr)
                    `SAMPLER_REG_CTRL:  enable <= pwdata[0];
                    // clamp to the shortest usable bit time.
                    `SAMPLER_REG_BAUD:  baud_div <= (pwdata[15:0] < 16'd4) ? 16'd4 : pwdata[15:0];
                    `SAMPLER_REG_DECIM: decim <= (pwdata[7:0] == 8'd0) ? 8'd1 : pwdata[7:0];
                    `SAMPLER_REG_DUTY:  duty <= pwdata[7:0];
                    default:            err_count <= '0;
                endcase
            end
        end
    end

    ////////////////////
    // pwm counter with a period of 256 clocks.
    always_ff @(posedge clk) begin
        if (reset) begin
            pwm_cnt <= '0;
            pwm_out <= 1'b0;
        end else begin
            pwm_cnt <= pwm_cnt + 8'd1;
            pwm_out <= pwm_cnt < duty;
        end
    end

    apb_penable_psel: assert property (@(posedge clk) disable iff (reset) penable |-> psel);

endmodule

`default_nettype wire

//--- src/sampler_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "sampler_settings.svh"

module sampler_top (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire [`SAMPLER_ADDR_BITS-1:0] paddr,
    input  wire [31:0]                   pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  wire                          lvds_in,
    input  wire                          rx_serial,
    output logic                         tx_out,
    output logic                         comp_out,
    output logic                         pwm_out,
    output logic                         led_busy,
    output logic                         led_err
);

    import serial_pkg::*;
    import capture_pkg::*;

    baud_div_t baud_div;
    decim_t    decim;
    byte_t     rx_dat;
    logic      rx_stb;
    logic      rx_err;
    logic      enable;
    logic      busy;
    sample_t   sample;
    logic      sample_valid;
    logic      sample_ready;
    sample_t   dump_sample;
    logic      dump_valid;
    logic      dump_last;
    logic      dump_ready;

    assign led_busy = busy;

    acia_rx acia_rx_inst (
        .clk(clk), .reset(reset), .baud_div(baud_div), .rx_serial(rx_serial),
        .rx_dat(rx_dat), .rx_stb(rx_stb), .rx_err(rx_err)
    );

    digitizer digitizer_inst (
        .clk(clk), .reset(reset), .lvds_in(lvds_in), .decim(decim), .comp_in(comp_out),
        .sample(sample), .sample_valid(sample_valid), .sample_ready(sample_ready)
    );

    capture_ctrl capture_ctrl_inst (
        .clk(clk), .reset(reset), .enable(enable), .rx_dat(rx_dat), .rx_stb(rx_stb),
        .sample(sample), .sample_valid(sample_valid), .sample_ready(sample_ready),
        .dump_sample(dump_sample), .dump_valid(dump_valid), .dump_last(dump_last),
        .dump_ready(dump_ready), .busy(busy)
    );

    hex_dump hex_dump_inst (
        .clk(clk), .reset(reset), .baud_div(baud_div), .dump_sample(dump_sample),
        .dump_valid(dump_valid), .dump_last(dump_last), .dump_ready(dump_ready),
        .tx_serial(tx_out)
    );

    apb_regs apb_regs_inst (
        .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .rx_err(rx_err), .busy(busy), .enable(enable),
        .baud_div(baud_div), .decim(decim), .pwm_out(pwm_out), .led_err(led_err)
    );

endmodule

`default_nettype wire

//--- tests/sampler_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "sampler_settings.svh"

module sampler_tb;

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [`SAMPLER_ADDR_BITS-1:0] paddr;
    logic [31:0]                   pwdata;
    logic [31:0]                   prdata;
    logic                          pready;
    logic                          pslverr;
    logic                          lvds_in;
    logic                          rx_serial;
    logic                          tx_out;
    logic                          comp_out;
    logic                          pwm_out;
    logic                          led_busy;
    logic                          led_err;

    int         errors = 0;
    int         checks = 0;
    int         baud = 16;
    int         lvds_mode = 0;
    int         lvds_phase = 0;
    logic [2:0] lvds_hist = '0;
    logic [7:0] rx_q[$];

    sampler_top sampler_top_inst (
        .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .lvds_in(lvds_in), .rx_serial(rx_serial), .tx_out(tx_out),
        .comp_out(comp_out), .pwm_out(pwm_out), .led_busy(led_busy), .led_err(led_err)
    );

    always #10 clk = ~clk;

    // mode 0 low, 1 high, 2 one high clock in every 4.
    // comp_out trails the driven input by two synchronizer stages and one flop.
    always @(negedge clk) begin
        compare("comp_out delay", lvds_hist[2], comp_out);
        lvds_phase = (lvds_phase + 1) % 4;
        case (lvds_mode)
            1: lvds_in = 1'b1;
            2: lvds_in = (lvds_phase == 0);
            default: lvds_in = 1'b0;
        endcase
        lvds_hist = {lvds_hist[1:0], lvds_in};
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    function automatic logic [7:0] hex_digit(input logic [3:0] nib);
        if (nib < 4'd10)
            return "0" + nib;
        return "A" + (nib - 4'd10);
    endfunction

    // count copies of "HH " and then CR LF.
    function automatic string expected_dump(input int count, input logic [7:0] value);
        string s;
        s = "";
        for (int i = 0; i < count; i++)
            s = {s, $sformatf("%c%c ", hex_digit(value[7:4]), hex_digit(value[3:0]))};
        return {s, $sformatf("%c%c", 8'h0D, 8'h0A)};
    endfunction

    ////////////////////
    // apb master.
    task automatic apb_access(input logic write, input logic [`SAMPLER_ADDR_BITS-1:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic err);
        int cycles;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        cycles  = 0;
        @(posedge clk);
        while (!pready && cycles < 16) begin
            @(posedge clk);
            cycles++;
        end
        if (!pready) begin
            errors++;
            $display("apb access to %0h timed out with pready low", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [`SAMPLER_ADDR_BITS-1:0] addr,
                             input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [`SAMPLER_ADDR_BITS-1:0] addr,
                            output logic [31:0] rdata, output logic err);
        apb_access(1'b0, addr, 32'd0, rdata, err);
    endtask

    ////////////////////
    // uart side.
    task automatic uart_send(input logic [7:0] data, input logic stop_bit);
        @(negedge clk);
        rx_serial = 1'b0;
        repeat (baud) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx_serial = data[i];
            repeat (baud) @(negedge clk);
        end
        rx_serial = stop_bit;
        repeat (baud) @(negedge clk);
        rx_serial = 1'b1;
        repeat (2 * baud) @(negedge clk);
    endtask

    // decodes tx_out at mid-bit.
    initial begin : tx_decoder
        logic       prev;
        logic [7:0] ch;
        prev = 1'b1;
        forever begin
            @(negedge clk);
            if (prev === 1'b1 && tx_out === 1'b0) begin
                repeat (baud / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (baud) @(negedge clk);
                    ch[i] = tx_out;
                end
                repeat (baud) @(negedge clk);
                if (tx_out !== 1'b1) begin
                    errors++;
                    $display("stop bit on tx_out was not high after character %0h", ch);
                end
                rx_q.push_back(ch);
                prev = 1'b1;
            end else begin
                prev = tx_out;
            end
        end
    end

    task automatic wait_chars(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (rx_q.size() < n && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (rx_q.size() < n) begin
            errors++;
            $display("timed out with %0d of %0d characters seen on tx_out", rx_q.size(), n);
        end
    endtask

    task automatic run_burst(input string name, input int count, input logic [7:0] value,
                             input bit check_busy);
        string       exp;
        logic [31:0] rdata;
        logic        err;
        exp = expected_dump(count, value);
        rx_q.delete();
        uart_send(count[7:0], 1'b1);
        if (check_busy) begin
            apb_read(`SAMPLER_REG_STATUS, rdata, err);
            compare({name, " busy during burst"}, 32'd1, rdata[0]);
            compare({name, " led_busy during burst"}, 32'd1, led_busy);
        end
        wait_chars(exp.len(), count * (30 * baud + 300) + 20 * baud + 2000);
        // the line stays quiet afterwards with no extra characters.
        repeat (20 * baud) @(negedge clk);
        compare({name, " length"}, exp.len(), rx_q.size());
        for (int i = 0; i < exp.len() && i < rx_q.size(); i++) begin
            if (rx_q[i] !== exp[i]) begin
                compare($sformatf("%s char %0d", name, i), exp[i], rx_q[i]);
                break;
            end
        end
        if (check_busy) begin
            apb_read(`SAMPLER_REG_STATUS, rdata, err);
            compare({name, " busy after burst"}, 32'd0, rdata[0]);
            compare({name, " led_busy after burst"}, 32'd0, led_busy);
        end
    endtask

    // watchdog over the whole run.
    initial begin
        repeat (200000) @(posedge clk);
        $display("simulation stopped by the watchdog before all tests finished");
        $display("Test failed");
        $finish;
    end

    ////////////////////
    initial begin
        logic [31:0] rdata;
        logic        err;
        int          decim;
        int          count;
        int          duty;
        int          highs;
        void'($urandom(32'h201917c9));
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        rx_serial = 1'b1;
        lvds_in   = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        // register access.
        apb_read(`SAMPLER_REG_BAUD, rdata, err);
        compare("baud reset", 32'd16, rdata);
        compare("mapped pslverr", 32'd0, err);
        apb_read(`SAMPLER_REG_DECIM, rdata, err);
        compare("decim reset", 32'd64, rdata);
        apb_read(`SAMPLER_REG_DUTY, rdata, err);
        compare("duty reset", 32'd0, rdata);
        apb_write(`SAMPLER_REG_BAUD, 32'd20, err);
        apb_read(`SAMPLER_REG_BAUD, rdata, err);
        compare("baud readback", 32'd20, rdata);
        apb_write(`SAMPLER_REG_DECIM, 32'd100, err);
        apb_read(`SAMPLER_REG_DECIM, rdata, err);
        compare("decim readback", 32'd100, rdata);
        apb_write(`SAMPLER_REG_DUTY, 32'h5A, err);
        apb_read(`SAMPLER_REG_DUTY, rdata, err);
        compare("duty readback", 32'h5A, rdata);
        apb_write(5'h14, 32'h1234, err);
        compare("unmapped write pslverr", 32'd1, err);
        apb_read(5'h14, rdata, err);
        compare("unmapped read pslverr", 32'd1, err);
        apb_write(`SAMPLER_REG_BAUD, 32'd2, err);
        apb_read(`SAMPLER_REG_BAUD, rdata, err);
        compare("baud clamp", 32'd4, rdata);
        apb_write(`SAMPLER_REG_BAUD, baud, err);
        apb_write(`SAMPLER_REG_CTRL, 32'd1, err);

        // constant input.
        decim = $urandom_range(1, 255);
        apb_write(`SAMPLER_REG_DECIM, decim, err);
        lvds_mode = 1;
        repeat (600) @(negedge clk);
        run_burst("constant high", 3, decim[7:0], 1'b1);
        lvds_mode = 0;
        repeat (600) @(negedge clk);
        run_burst("constant low", 3, 8'h00, 1'b1);

        // one high in four gives 16 per window of 64.
        apb_write(`SAMPLER_REG_DECIM, 32'd64, err);
        lvds_mode = 2;
        repeat (600) @(negedge clk);
        count = $urandom_range(1, 6);
        run_burst("duty pattern", count, 8'h10, 1'b0);

        // ignored commands.
        rx_q.delete();
        uart_send(8'd0, 1'b1);
        repeat (3000) @(negedge clk);
        compare("zero command output", 32'd0, rx_q.size());
        apb_write(`SAMPLER_REG_CTRL, 32'd0, err);
        uart_send(8'd3, 1'b1);
        repeat (3000) @(negedge clk);
        compare("disabled command output", 32'd0, rx_q.size());
        apb_read(`SAMPLER_REG_STATUS, rdata, err);
        compare("disabled busy", 32'd0, rdata[0]);
        apb_write(`SAMPLER_REG_CTRL, 32'd1, err);

        // framing error.
        uart_send(8'd3, 1'b0);
        repeat (3000) @(negedge clk);
        compare("framing error output", 32'd0, rx_q.size());
        apb_read(`SAMPLER_REG_STATUS, rdata, err);
        compare("err_count after framing error", 32'd1, rdata[15:8]);
        compare("busy after framing error", 32'd0, rdata[0]);
        compare("led_err set", 32'd1, led_err);
        apb_write(`SAMPLER_REG_STATUS, 32'd0, err);
        apb_read(`SAMPLER_REG_STATUS, rdata, err);
        compare("err_count cleared", 32'd0, rdata[15:8]);
        compare("led_err cleared", 32'd0, led_err);

        // pwm over one full period.
        duty = $urandom_range(0, 255);
        apb_write(`SAMPLER_REG_DUTY, duty, err);
        repeat (4) @(negedge clk);
        highs = 0;
        repeat (256) begin
            @(negedge clk);
            if (pwm_out === 1'b1)
                highs++;
        end
        compare("pwm high cycles", duty, highs);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/serial_pkg.sv
src/capture_pkg.sv
src/acia_rx.sv
src/digitizer.sv
src/capture_ctrl.sv
src/hex_dump.sv
src/apb_regs.sv
src/sampler_top.sv
tests/sampler_tb.sv

//--- Bender.yml
package:
  name: sampler

sources:
  - include_dirs:
      - src
    files:
      - src/serial_pkg.sv
      - src/capture_pkg.sv
      - src/acia_rx.sv
      - src/digitizer.sv
      - src/capture_ctrl.sv
      - src/hex_dump.sv
      - src/apb_regs.sv
      - src/sampler_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/sampler_tb.sv
